// ==== design/rv_pkg.sv ====
`default_nettype none

// ISA-side definitions shared by the fetch stage and its testbench
package rv_pkg;

    // data and address width
    localparam int XLEN = 32;

    // bytes per instruction, the sequential pc step
    localparam int INST_BYTES = 4;

    // major opcode field, inst[6:0]
    localparam int OPCODE_W = 7;

    // funct3 field position, used to qualify jalr
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_W = 3;

    // major opcodes the fetch stage cares about
    typedef enum logic [OPCODE_W-1:0] {
        // jump and link, pc relative, followed by fetch
        OP_JAL    = 7'b1101111,
        // jump and link register, target comes from an alu
        OP_JALR   = 7'b1100111,
        // conditional branch, target comes from the branch unit
        OP_BRANCH = 7'b1100011,
        // register-immediate alu ops, addi among them
        OP_IMM    = 7'b0010011,
        // anything else, fetched straight through
        OP_OTHER  = 7'b0110011
    } opcode_e;

    // addi x0, x0, 0
    // issued whenever no real instruction goes to the decoder
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

    // jalr only exists with funct3 zero
    localparam logic [FUNCT3_W-1:0] FUNCT3_JALR = 3'b000;

endpackage

`default_nettype wire

// ==== design/fetch_pkg.sv ====
`default_nettype none

// instruction cache geometry and refill engine states
package fetch_pkg;

    // word interleaved banks, selected by pc bit 2
    localparam int NUM_BANKS = 2;
    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int BANK_LSB = 2;

    // direct-mapped entries per bank, index is pc[5:3]
    localparam int SETS = 8;
    localparam int INDEX_W = $clog2(SETS);
    localparam int INDEX_LSB = BANK_LSB + BANK_W;

    // tag is everything above the index, pc[31:6]
    localparam int TAG_LSB = INDEX_LSB + INDEX_W;
    localparam int TAG_W = rv_pkg::XLEN - TAG_LSB;

    // refill engine
    typedef enum logic [1:0] {
        // waiting for a miss from the fetch unit
        IDLE,
        // mem_req held until mem_valid
        WAIT,
        // one cycle for the written bank to show a hit
        DONE
    } refill_state_e;

endpackage

`default_nettype wire

// ==== design/icache_bank.sv ====
`default_nettype none

// one direct-mapped bank: valid bit, tag and word per entry
// read is combinational, write lands at the edge with fill_we high
module icache_bank (
    input  logic                          clk,
    input  logic                          arst_n,

    // refill side
    input  logic                          fill_we,
    input  logic [fetch_pkg::INDEX_W-1:0] fill_index,
    input  logic [fetch_pkg::TAG_W-1:0]   fill_tag,
    input  logic [rv_pkg::XLEN-1:0]       fill_data,

    // fetch side
    input  logic [rv_pkg::XLEN-1:0]       rd_addr,
    output logic                          rd_hit,
    output logic [rv_pkg::XLEN-1:0]       rd_data
);

    logic [fetch_pkg::SETS-1:0]    valid_q;
    logic [fetch_pkg::TAG_W-1:0]   tag_q [fetch_pkg::SETS];
    logic [rv_pkg::XLEN-1:0]       data_q [fetch_pkg::SETS];

    logic [fetch_pkg::INDEX_W-1:0] rd_index;
    logic [fetch_pkg::TAG_W-1:0]   rd_tag;

    // split the fetch address, bank select bit is dropped here
    assign rd_index = rd_addr[fetch_pkg::INDEX_LSB +: fetch_pkg::INDEX_W];
    assign rd_tag   = rd_addr[fetch_pkg::TAG_LSB +: fetch_pkg::TAG_W];

    // valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (fill_we) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_q[fill_index]  <= fill_tag;
            data_q[fill_index] <= fill_data;
        end
    end

    // lookup
    always_comb begin
        rd_hit  = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
        rd_data = data_q[rd_index];
    end

    // a write with unknown index or data would poison the entry for good
    a_fill_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        fill_we |-> !$isunknown({fill_index, fill_data})
    ) else $error("icache_bank: fill with unknown index or data");

endmodule

`default_nettype wire

// ==== design/icache_refill.sv ====
`default_nettype none

// miss handling
// takes a miss from the fetch unit, fetches one word from external
// memory and writes it into the bank picked by address bit 2
module icache_refill (
    input  logic                            clk,
    input  logic                            arst_n,

    // from fetch unit
    input  logic                            miss_req,
    input  logic [rv_pkg::XLEN-1:0]         miss_addr,

    // external memory
    output logic                            mem_req,
    output logic [rv_pkg::XLEN-1:0]         mem_addr,
    input  logic                            mem_valid,
    input  logic [rv_pkg::XLEN-1:0]         mem_data,

    // to the banks
    output logic [fetch_pkg::NUM_BANKS-1:0] fill_we,
    output logic [fetch_pkg::INDEX_W-1:0]   fill_index,
    output logic [fetch_pkg::TAG_W-1:0]     fill_tag,
    output logic [rv_pkg::XLEN-1:0]         fill_data
);

    fetch_pkg::refill_state_e        state_q;
    fetch_pkg::refill_state_e        state_d;

    // address of the miss being served
    logic [rv_pkg::XLEN-1:0]         addr_q;
    logic [fetch_pkg::BANK_W-1:0]    fill_bank;
    logic                            fill_fire;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IDLE: begin
                if (miss_req) begin
                    state_d = fetch_pkg::WAIT;
                end
            end
            fetch_pkg::WAIT: begin
                if (mem_valid) begin
                    state_d = fetch_pkg::DONE;
                end
            end
            // miss_req is still high here, let the hit show first
            fetch_pkg::DONE: state_d = fetch_pkg::IDLE;
            default:         state_d = fetch_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= fetch_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // latch the miss address when leaving IDLE
    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::IDLE && miss_req) begin
            addr_q <= miss_addr;
        end
    end

    // memory request held for the whole WAIT state
    assign mem_req  = (state_q == fetch_pkg::WAIT);
    assign mem_addr = {addr_q[rv_pkg::XLEN-1:2], 2'b00};

    // bank write in the cycle mem_data is valid
    assign fill_fire = mem_req && mem_valid;
    assign fill_bank = addr_q[fetch_pkg::BANK_LSB +: fetch_pkg::BANK_W];

    always_comb begin
        for (int b = 0; b < fetch_pkg::NUM_BANKS; b++) begin
            fill_we[b] = fill_fire && (fill_bank == fetch_pkg::BANK_W'(b));
        end
    end

    assign fill_index = addr_q[fetch_pkg::INDEX_LSB +: fetch_pkg::INDEX_W];
    assign fill_tag   = addr_q[fetch_pkg::TAG_LSB +: fetch_pkg::TAG_W];
    // word kept in memory byte order, fetch unit swaps it
    assign fill_data  = mem_data;

    a_fill_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(fill_we)
    ) else $error("icache_refill: more than one bank written");

    // memory only answers an outstanding request
    a_valid_in_wait: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_valid |-> (state_q == fetch_pkg::WAIT)
    ) else $error("icache_refill: mem_valid outside WAIT");

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`default_nettype none

// pc state, cache read, jal follow, jalr and branch stalls
module fetch_unit (
    input  logic                                               clk,
    input  logic                                               arst_n,
    input  logic                                               rdy,
    input  logic                                               issue,

    // redirects, jmp 0 wins over jmp 1, branch wins over both
    input  logic                                               jmp_en0,
    input  logic                                               jmp_en1,
    input  logic [rv_pkg::XLEN-1:0]                            jmp_addr0,
    input  logic [rv_pkg::XLEN-1:0]                            jmp_addr1,
    input  logic                                               branch_en,
    input  logic [rv_pkg::XLEN-1:0]                            branch_target,

    // cache banks
    output logic [rv_pkg::XLEN-1:0]                            rd_addr,
    input  logic [fetch_pkg::NUM_BANKS-1:0]                    bank_hit,
    input  logic [fetch_pkg::NUM_BANKS-1:0][rv_pkg::XLEN-1:0]  bank_data,

    // refill engine
    output logic                                               miss_req,
    output logic [rv_pkg::XLEN-1:0]                            miss_addr,

    // decoder
    output logic                                               inst_valid,
    output logic [rv_pkg::XLEN-1:0]                            inst_pc,
    output logic [rv_pkg::XLEN-1:0]                            inst
);

    logic [rv_pkg::XLEN-1:0]      pc_q;
    logic                         jmp_stall_q;
    logic                         branch_mode_q;

    logic [fetch_pkg::BANK_W-1:0] bank_sel;
    logic                         hit;
    logic [rv_pkg::XLEN-1:0]      raw_word;
    logic [rv_pkg::XLEN-1:0]      word;
    rv_pkg::opcode_e              opcode;
    logic                         stalled;
    logic                         is_jal;
    logic                         is_jalr;
    logic                         is_branch;
    logic [rv_pkg::XLEN-1:0]      jal_imm;
    logic [rv_pkg::XLEN-1:0]      pc_step;
    logic                         jmp_en;
    logic [rv_pkg::XLEN-1:0]      jmp_addr;

    assign jmp_en   = jmp_en0 || jmp_en1;
    assign jmp_addr = jmp_en0 ? jmp_addr0 : jmp_addr1;

    // all banks see the pc, pc bit 2 picks the answer
    assign rd_addr  = pc_q;
    assign bank_sel = pc_q[fetch_pkg::BANK_LSB +: fetch_pkg::BANK_W];
    assign hit      = bank_hit[bank_sel];
    assign raw_word = bank_data[bank_sel];

    // memory delivers words byte swapped
    assign word = {raw_word[7:0], raw_word[15:8], raw_word[23:16], raw_word[31:24]};

    always_comb begin
        case (word[rv_pkg::OPCODE_W-1:0])
            rv_pkg::OP_JAL:    opcode = rv_pkg::OP_JAL;
            rv_pkg::OP_JALR:   opcode = rv_pkg::OP_JALR;
            rv_pkg::OP_BRANCH: opcode = rv_pkg::OP_BRANCH;
            rv_pkg::OP_IMM:    opcode = rv_pkg::OP_IMM;
            default:           opcode = rv_pkg::OP_OTHER;
        endcase
    end

    assign stalled   = jmp_stall_q || branch_mode_q;
    assign is_jal    = (opcode == rv_pkg::OP_JAL);
    assign is_jalr   = (opcode == rv_pkg::OP_JALR) &&
                       (word[rv_pkg::FUNCT3_LSB +: rv_pkg::FUNCT3_W] == rv_pkg::FUNCT3_JALR);
    assign is_branch = (opcode == rv_pkg::OP_BRANCH);

    // J-type immediate, sign extended
    assign jal_imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

    // while stalled a fetched jal is not followed
    assign pc_step = (is_jal && !stalled) ? jal_imm : rv_pkg::XLEN'(rv_pkg::INST_BYTES);

    // refill request, dropped as soon as the word hits
    assign miss_req  = rdy && issue && !branch_en && !jmp_en && !hit;
    assign miss_addr = pc_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q          <= '0;
            jmp_stall_q   <= 1'b0;
            branch_mode_q <= 1'b0;
            inst_valid    <= 1'b0;
            inst_pc       <= '0;
            inst          <= rv_pkg::NOP_WORD;
        end else if (rdy) begin
            if (branch_en) begin
                branch_mode_q <= 1'b0;
                pc_q          <= branch_target;
                inst_pc       <= branch_target;
                inst_valid    <= 1'b0;
                inst          <= rv_pkg::NOP_WORD;
            end else if (jmp_en) begin
                jmp_stall_q <= 1'b0;
                pc_q        <= jmp_addr;
                inst_pc     <= jmp_addr;
                inst_valid  <= 1'b0;
                inst        <= rv_pkg::NOP_WORD;
            end else if (issue) begin
                inst_pc <= pc_q;
                if (hit) begin
                    inst_valid <= 1'b1;
                    pc_q       <= pc_q + pc_step;
                    if (stalled) begin
                        inst <= rv_pkg::NOP_WORD;
                    end else begin
                        inst          <= word;
                        jmp_stall_q   <= is_jalr;
                        branch_mode_q <= is_branch;
                    end
                end else begin
                    // refill pending
                    inst_valid <= 1'b0;
                    inst       <= rv_pkg::NOP_WORD;
                end
            end
        end
    end

    // redirect targets and jal offsets must keep the pc on word boundaries
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        pc_q[1:0] == 2'b00
    ) else $error("fetch_unit: pc not word aligned");

endmodule

`default_nettype wire

// ==== design/fetch_top.sv ====
`default_nettype none

// instruction fetch subsystem
// refill engine, banked instruction cache and fetch unit
module fetch_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      rdy,
    input  logic                      issue,

    // alu and branch unit redirects
    input  logic                      jmp_en0,
    input  logic                      jmp_en1,
    input  logic [rv_pkg::XLEN-1:0]   jmp_addr0,
    input  logic [rv_pkg::XLEN-1:0]   jmp_addr1,
    input  logic                      branch_en,
    input  logic [rv_pkg::XLEN-1:0]   branch_target,

    // external memory
    output logic                      mem_req,
    output logic [rv_pkg::XLEN-1:0]   mem_addr,
    input  logic                      mem_valid,
    input  logic [rv_pkg::XLEN-1:0]   mem_data,

    // decoder
    output logic                      inst_valid,
    output logic [rv_pkg::XLEN-1:0]   inst_pc,
    output logic [rv_pkg::XLEN-1:0]   inst
);

    logic                                              miss_req;
    logic [rv_pkg::XLEN-1:0]                           miss_addr;

    logic [fetch_pkg::NUM_BANKS-1:0]                   fill_we;
    logic [fetch_pkg::INDEX_W-1:0]                     fill_index;
    logic [fetch_pkg::TAG_W-1:0]                       fill_tag;
    logic [rv_pkg::XLEN-1:0]                           fill_data;

    logic [rv_pkg::XLEN-1:0]                           rd_addr;
    logic [fetch_pkg::NUM_BANKS-1:0]                   bank_hit;
    logic [fetch_pkg::NUM_BANKS-1:0][rv_pkg::XLEN-1:0] bank_data;

    icache_refill u_refill (
        .clk        (clk),
        .arst_n     (arst_n),
        .miss_req   (miss_req),
        .miss_addr  (miss_addr),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data),
        .fill_we    (fill_we),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .fill_data  (fill_data)
    );

    // one bank per pc bit 2 value, shared fill bus
    for (genvar g = 0; g < fetch_pkg::NUM_BANKS; g++) begin : g_bank
        icache_bank u_bank (
            .clk        (clk),
            .arst_n     (arst_n),
            .fill_we    (fill_we[g]),
            .fill_index (fill_index),
            .fill_tag   (fill_tag),
            .fill_data  (fill_data),
            .rd_addr    (rd_addr),
            .rd_hit     (bank_hit[g]),
            .rd_data    (bank_data[g])
        );
    end

    fetch_unit u_fetch (
        .clk           (clk),
        .arst_n        (arst_n),
        .rdy           (rdy),
        .issue         (issue),
        .jmp_en0       (jmp_en0),
        .jmp_en1       (jmp_en1),
        .jmp_addr0     (jmp_addr0),
        .jmp_addr1     (jmp_addr1),
        .branch_en     (branch_en),
        .branch_target (branch_target),
        .rd_addr       (rd_addr),
        .bank_hit      (bank_hit),
        .bank_data     (bank_data),
        .miss_req      (miss_req),
        .miss_addr     (miss_addr),
        .inst_valid    (inst_valid),
        .inst_pc       (inst_pc),
        .inst          (inst)
    );

endmodule

`default_nettype wire

// ==== verif/fetch_ref.svh ====
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

// lcg shared by the image builder and the stimulus
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// memory keeps every word with its bytes reversed
function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    logic [31:0] r;
    r = {<<8{w}};
    return r;
endfunction

// J-type immediate, sign extended
function automatic logic [31:0] jal_offset(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
endfunction

// 64 words of addi, jal, jalr, branch and register ops
task automatic build_image();
    logic [31:0] w;
    logic [20:0] off;
    int tgt;
    for (int i = 0; i < 64; i++) begin
        stim_seed = lcg_next(stim_seed);
        case (stim_seed[30:28])
            3'd0: begin
                tgt = i + int'(stim_seed[19:16]) - 5;
                if (tgt == i || tgt < 0 || tgt > 63) begin
                    tgt = (i + 2) % 64;
                end
                off = 21'((tgt - i) * 4);
                w = {off[20], off[10:1], off[11], off[19:12], stim_seed[11:7], 7'b1101111};
                // a backward jal lands on a branch, so no loop can spin forever
                if (tgt < i) begin
                    image_mem[6'(tgt)] = swap_bytes({stim_seed[24:0], 7'b1100011});
                end
            end
            3'd1: w = {stim_seed[31:15], 3'b000, stim_seed[11:7], 7'b1100111};
            3'd2: w = {stim_seed[31:7], 7'b1100011};
            3'd3: w = {stim_seed[31:7], 7'b0110011};
            default: w = {stim_seed[31:15], 3'b000, stim_seed[11:7], 7'b0010011};
        endcase
        image_mem[6'(i)] = swap_bytes(w);
    end
endtask

// expected decoder word for a hit at exp_pc, then advance the model
function automatic logic [31:0] ref_step();
    logic [31:0] w;
    w = swap_bytes(image_mem[exp_pc[7:2]]);
    if (exp_jstall || exp_bmode) begin
        exp_pc = exp_pc + 32'd4;
        return rv_pkg::NOP_WORD;
    end
    if (w[6:0] == rv_pkg::OP_JAL) begin
        exp_pc = exp_pc + jal_offset(w);
    end else begin
        exp_pc = exp_pc + 32'd4;
    end
    exp_jstall = (w[6:0] == rv_pkg::OP_JALR) && (w[14:12] == 3'b000);
    exp_bmode = (w[6:0] == rv_pkg::OP_BRANCH);
    return w;
endfunction

// branch first, then jump port 0, then jump port 1
function automatic void ref_redirect(input logic b_en, input logic [31:0] b_tgt,
                                     input logic j0, input logic [31:0] a0,
                                     input logic j1, input logic [31:0] a1);
    if (b_en) begin
        exp_pc = b_tgt;
        exp_bmode = 1'b0;
    end else if (j0 || j1) begin
        exp_pc = j0 ? a0 : a1;
        exp_jstall = 1'b0;
    end
endfunction

// direct-mapped lookup, bank pc[2], index pc[5:3], tag pc[31:6]
function automatic logic is_resident(input logic [31:0] a);
    return shadow_vld[a[2]][a[5:3]] && (shadow_tag[a[2]][a[5:3]] == a[31:6]);
endfunction

`endif

// ==== verif/fetch_tb.sv ====
`default_nettype none

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OUTPUTS = 400;
    localparam int TIMEOUT_NS = NUM_OUTPUTS * 12 * 10;

    logic clk = 1'b0;
    logic arst_n, rdy, issue;
    logic jmp_en0, jmp_en1, branch_en;
    logic [31:0] jmp_addr0, jmp_addr1, branch_target;
    logic mem_req, mem_valid;
    logic [31:0] mem_addr, mem_data;
    logic inst_valid;
    logic [31:0] inst_pc, inst;

    logic [31:0] image_mem [64];
    logic [31:0] stim_seed;
    logic [31:0] mem_seed;
    logic [31:0] exp_pc;
    logic [31:0] exp_inst;
    logic exp_jstall, exp_bmode;
    logic [25:0] shadow_tag [2][8];
    logic shadow_vld [2][8];
    logic fire_q, hold_q, redir_q, redir, mem_req_q, prev_valid, redir_branch;
    logic [31:0] prev_pc;
    int n_checked = 0;
    int n_mismatch = 0;
    int n_other = 0;
    int n_fills = 0;
    int mem_wait;
    int redir_wait;

    `include "fetch_ref.svh"

    fetch_top UUT (
        .clk(clk), .arst_n(arst_n), .rdy(rdy), .issue(issue),
        .jmp_en0(jmp_en0), .jmp_en1(jmp_en1), .jmp_addr0(jmp_addr0), .jmp_addr1(jmp_addr1),
        .branch_en(branch_en), .branch_target(branch_target),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_valid(mem_valid), .mem_data(mem_data),
        .inst_valid(inst_valid), .inst_pc(inst_pc), .inst(inst)
    );

    always #5 clk = ~clk;

    task automatic note_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        n_mismatch++;
        $display("MISMATCH %s got %08h expected %08h at %0t", name, got, want, $time);
    endtask

    task automatic log_failure(input string what);
        n_other++;
        $display("ERROR %s at %0t", what, $time);
    endtask

    task automatic print_counts();
        $display("outputs checked %0d, mismatches %0d, other errors %0d",
                 n_checked, n_mismatch, n_other);
    endtask

    // resolves the pending stall with random targets inside the image
    task automatic drive_redirect();
        stim_seed = lcg_next(stim_seed);
        rdy = 1'b1;
        jmp_addr0 = {24'd0, stim_seed[21:16], 2'b00};
        jmp_addr1 = {24'd0, stim_seed[13:8], 2'b00};
        branch_target = {24'd0, stim_seed[29:24], 2'b00};
        if (redir_branch) begin
            branch_en = 1'b1;
            jmp_en0 = stim_seed[31];
        end else begin
            jmp_en0 = stim_seed[31] | !stim_seed[30];
            jmp_en1 = stim_seed[30];
        end
    endtask

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        while (n_checked < NUM_OUTPUTS) begin
            @(posedge clk);
        end
        print_counts();
        if (n_mismatch + n_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // rdy, issue and redirect strobes
    initial begin
        rdy = 1'b0;
        issue = 1'b0;
        jmp_en0 = 1'b0;
        jmp_en1 = 1'b0;
        branch_en = 1'b0;
        jmp_addr0 = '0;
        jmp_addr1 = '0;
        branch_target = '0;
        redir_branch = 1'b0;
        redir_wait = 0;
        stim_seed = 32'h8920;
        build_image();
        @(posedge arst_n);
        forever begin
            @(posedge clk);
            #1;
            stim_seed = lcg_next(stim_seed);
            rdy = (stim_seed[30:28] != 3'd0);
            issue = (stim_seed[27:26] != 2'd0);
            branch_en = 1'b0;
            jmp_en0 = 1'b0;
            jmp_en1 = 1'b0;
            if (redir_wait > 0) begin
                redir_wait--;
                if (redir_wait == 0) begin
                    drive_redirect();
                end
            end else if (inst_valid && (inst[6:0] == rv_pkg::OP_JALR ||
                                        inst[6:0] == rv_pkg::OP_BRANCH)) begin
                redir_wait = 1 + int'(stim_seed[25:24]);
                redir_branch = (inst[6:0] == rv_pkg::OP_BRANCH);
            end
        end
    end

    // external memory, 1 to 4 cycles per request
    initial begin
        mem_valid = 1'b0;
        mem_data = '0;
        mem_wait = 0;
        mem_seed = 32'h8920;
        forever begin
            @(posedge clk);
            #1;
            mem_valid = 1'b0;
            if (mem_req) begin
                if (mem_wait == 0) begin
                    mem_seed = lcg_next(mem_seed);
                    mem_wait = 1 + int'(mem_seed[29:28]);
                end
                mem_wait--;
                if (mem_wait == 0) begin
                    mem_valid = 1'b1;
                    mem_data = image_mem[mem_addr[7:2]];
                end
            end
        end
    end

    // outputs of the last edge, then the redirect for the coming one
    always @(negedge clk) begin
        if (!arst_n) begin
            if (mem_req !== 1'b0 || inst_valid !== 1'b0 || inst !== rv_pkg::NOP_WORD) begin
                log_failure("outputs not idle during reset");
            end
            exp_pc = '0;
            exp_jstall = 1'b0;
            exp_bmode = 1'b0;
            shadow_vld = '{default: 1'b0};
            fire_q = 1'b0;
            hold_q = 1'b0;
            redir_q = 1'b0;
            mem_req_q = 1'b0;
        end else begin
            if (inst_valid && n_fills == 0) begin
                log_failure("valid instruction before the first refill");
            end
            if (fire_q && inst_valid) begin
                if (inst_pc !== exp_pc) begin
                    note_mismatch("inst_pc", inst_pc, exp_pc);
                end
                exp_inst = ref_step();
                if (inst !== exp_inst) begin
                    note_mismatch("inst", inst, exp_inst);
                end
                n_checked++;
            end else if (fire_q || redir_q) begin
                if (inst_valid !== 1'b0 || inst !== rv_pkg::NOP_WORD) begin
                    note_mismatch("inst", inst, rv_pkg::NOP_WORD);
                end
            end else if (hold_q) begin
                if (inst_pc !== prev_pc) begin
                    note_mismatch("inst_pc", inst_pc, prev_pc);
                end
                if (inst_valid !== prev_valid) begin
                    note_mismatch("inst_valid", 32'(inst_valid), 32'(prev_valid));
                end
            end
            if (mem_req && !mem_req_q) begin
                if (mem_addr !== {exp_pc[31:2], 2'b00}) begin
                    note_mismatch("mem_addr", mem_addr, {exp_pc[31:2], 2'b00});
                end
                if (is_resident(mem_addr)) begin
                    log_failure("refill requested for a word already cached");
                end
            end
            if (mem_req && mem_valid) begin
                shadow_vld[mem_addr[2]][mem_addr[5:3]] = 1'b1;
                shadow_tag[mem_addr[2]][mem_addr[5:3]] = mem_addr[31:6];
                n_fills++;
            end
            redir = rdy && (branch_en || jmp_en0 || jmp_en1);
            if (redir) begin
                ref_redirect(branch_en, branch_target, jmp_en0, jmp_addr0, jmp_en1, jmp_addr1);
            end
            fire_q = rdy && issue && !redir;
            hold_q = !rdy || (!issue && !redir);
            redir_q = redir;
            prev_pc = inst_pc;
            prev_valid = inst_valid;
            mem_req_q = mem_req;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, %0d of %0d outputs seen",
                 TIMEOUT_NS, n_checked, NUM_OUTPUTS);
        print_counts();
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verif
design/rv_pkg.sv
design/fetch_pkg.sv
design/icache_bank.sv
design/icache_refill.sv
design/fetch_unit.sv
design/fetch_top.sv
verif/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module fetch_tb -o fetch_sim

result=$(./obj_dir/fetch_sim)
echo "$result"

if echo "$result" | grep -qxF "** PASS **"; then
    exit 0
else
    exit 1
fi
